/* include/sqed_consts.svh */
`ifndef SQED_CONSTS_SVH
`define SQED_CONSTS_SVH

// architectural register data width
`define XPR_LEN 32

// register address width, 32 architectural registers
`define REG_ADDR_WIDTH 5

// index within one half of the register file
// lower half holds originals, upper half holds duplicates
`define REG_IDX_WIDTH 4

// original/duplicate pairs
// pair 0 never flags, r0 is its own duplicate
`define NUM_PAIRS 16

// commit counter width
// counts wrap mod 32, only equality matters
`define COMMIT_CNT_WIDTH 5

// settling fsm state width
`define SETTLE_WIDTH 2

`endif

/* verilog/sqed_wb_pkg.sv */
`default_nettype none

`include "sqed_consts.svh"

// types for the core's retire port
package sqed_wb_pkg;

    // address split into half select and index
    // dup set means a register in 16..31
    typedef struct packed {
        logic                      dup;
        logic [`REG_IDX_WIDTH-1:0] idx;
    } reg_half_t;

    // same 5 bits, read as a register number or as half/index
    typedef union packed {
        logic [`REG_ADDR_WIDTH-1:0] raw;
        reg_half_t                  half;
    } reg_addr_u;

    // one retiring register write
    // valid is already qualified by stall and kill in the core
    typedef struct packed {
        logic                valid;
        reg_addr_u           addr;
        logic [`XPR_LEN-1:0] data;
    } wb_retire_t;

endpackage

`default_nettype wire

/* verilog/sqed_chk_pkg.sv */
`default_nettype none

`include "sqed_consts.svh"

// types for the monitor's counts and results
package sqed_chk_pkg;

    // original and duplicate commit counts
    typedef struct packed {
        logic [`COMMIT_CNT_WIDTH-1:0] orig;
        logic [`COMMIT_CNT_WIDTH-1:0] dup;
    } commit_counts_t;

    // start-up settling sequence
    typedef enum logic [`SETTLE_WIDTH-1:0] {
        SETTLE_IDLE,
        SETTLE_DX,
        SETTLE_DONE
    } settle_state_e;

    // registered check result
    // pair is the lowest differing pair index
    typedef struct packed {
        logic                      error;
        logic [`REG_IDX_WIDTH-1:0] pair;
    } qed_report_t;

endpackage

`default_nettype wire

/* verilog/commit_tally.sv */
`timescale 1ns/10ps
`default_nettype none

`include "sqed_consts.svh"

// settling tracker plus original/duplicate commit counters
module commit_tally (
    input  logic                         clk,
    input  logic                         reset,
    input  sqed_wb_pkg::wb_retire_t      retire,
    input  logic                         stall_dx,
    input  logic                         stall_wb,
    output sqed_chk_pkg::commit_counts_t counts,
    output logic                         settled
);

    sqed_chk_pkg::settle_state_e state;
    sqed_chk_pkg::settle_state_e state_next;

    // per-cycle commit strobes
    logic orig_commit;
    logic dup_commit;

    // r0 writes are nops, skip them
    // r0 never has dup set, so no extra check on the dup side
    assign orig_commit = retire.valid && !retire.addr.half.dup
                         && (retire.addr.raw != '0);
    assign dup_commit  = retire.valid && retire.addr.half.dup;

    // settling steps
    // idle waits for decode to move, then dx waits for writeback
    always_comb begin
        state_next = state;
        case (state)
            sqed_chk_pkg::SETTLE_IDLE: begin
                if (!stall_dx) begin
                    state_next = sqed_chk_pkg::SETTLE_DX;
                end
            end
            sqed_chk_pkg::SETTLE_DX: begin
                if (!stall_wb) begin
                    state_next = sqed_chk_pkg::SETTLE_DONE;
                end
            end
            sqed_chk_pkg::SETTLE_DONE: begin
                // sticky until reset
                state_next = sqed_chk_pkg::SETTLE_DONE;
            end
            default: begin
                state_next = sqed_chk_pkg::SETTLE_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= sqed_chk_pkg::SETTLE_IDLE;
        end else begin
            state <= state_next;
        end
    end

    assign settled = (state == sqed_chk_pkg::SETTLE_DONE);

    // counters held at zero until settled
    // the edge entering done still clears them
    always_ff @(posedge clk) begin
        if (reset || !settled) begin
            counts <= '0;
        end else begin
            // free-running wrap
            counts.orig <= counts.orig + {{(`COMMIT_CNT_WIDTH-1){1'b0}}, orig_commit};
            counts.dup  <= counts.dup + {{(`COMMIT_CNT_WIDTH-1){1'b0}}, dup_commit};
        end
    end

endmodule

`default_nettype wire

/* verilog/shadow_regfile.sv */
`timescale 1ns/10ps
`default_nettype none

`include "sqed_consts.svh"

// shadow copy of the architectural registers
// flags each original/duplicate pair that differs
module shadow_regfile (
    input  logic                    clk,
    input  logic                    reset,
    input  sqed_wb_pkg::wb_retire_t retire,
    output logic [`NUM_PAIRS-1:0]   pair_diff
);

    // r0 is not stored, it reads as zero
    logic [`XPR_LEN-1:0] regs [1:2*`NUM_PAIRS-1];

    logic wr_en;

    // writes to r0 are dropped
    assign wr_en = retire.valid && (retire.addr.raw != '0);

    // cleared on reset so originals and duplicates start equal
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int r = 1; r < 2 * `NUM_PAIRS; r++) begin
                regs[r] <= '0;
            end
        end else if (wr_en) begin
            regs[retire.addr.raw] <= retire.data;
        end
    end

    // pair i is ri against r(i+16)
    // r16 would pair with r0, so bit 0 stays low
    always_comb begin
        pair_diff[0] = 1'b0;
        for (int i = 1; i < `NUM_PAIRS; i++) begin
            pair_diff[i] = (regs[i] != regs[i + `NUM_PAIRS]);
        end
    end

endmodule

`default_nettype wire

/* verilog/consistency_check.sv */
`timescale 1ns/10ps
`default_nettype none

`include "sqed_consts.svh"

// combines commit counts and pair differences
// into check enable and a registered error report
module consistency_check (
    input  logic                         clk,
    input  logic                         reset,
    input  sqed_chk_pkg::commit_counts_t counts,
    input  logic                         settled,
    input  logic [`NUM_PAIRS-1:0]        pair_diff,
    output logic                         chk_en,
    output sqed_chk_pkg::qed_report_t    report
);

    logic                      any_diff;
    logic                      flag_now;
    logic [`REG_IDX_WIDTH-1:0] first_pair;

    // equal counts means every original has its duplicate retired,
    // so the register file should be in a consistent state
    assign chk_en = (counts.orig == counts.dup);

    assign any_diff = |pair_diff;

    // only trust the comparison once settled and balanced
    assign flag_now = chk_en && settled && any_diff;

    // priority search, lowest index wins
    // walk down so the last hit is the lowest
    always_comb begin
        first_pair = '0;
        for (int i = `NUM_PAIRS - 1; i > 0; i--) begin
            if (pair_diff[i]) begin
                first_pair = i[`REG_IDX_WIDTH-1:0];
            end
        end
    end

    // one edge behind the inputs
    always_ff @(posedge clk) begin
        if (reset) begin
            report <= '0;
        end else begin
            report.error <= flag_now;
            // pair reads zero when no error
            report.pair  <= flag_now ? first_pair : '0;
        end
    end

endmodule

`default_nettype wire

/* verilog/sqed_commit_monitor.sv */
`timescale 1ns/10ps
`default_nettype none

// sqed commit monitor top
// fed by the core's qualified retire port
module sqed_commit_monitor (
    input  logic                         clk,
    input  logic                         reset,
    input  sqed_wb_pkg::wb_retire_t      retire,
    input  logic                         stall_dx,
    input  logic                         stall_wb,
    output sqed_chk_pkg::commit_counts_t counts,
    output logic                         chk_en,
    output sqed_chk_pkg::qed_report_t    report
);

    // tally to check
    logic settled;

    // shadow file to check, one bit per pair
    logic [15:0] pair_diff;

    // counts and settling, side by side with the shadow file
    commit_tally tally0 (
        .clk      (clk),
        .reset    (reset),
        .retire   (retire),
        .stall_dx (stall_dx),
        .stall_wb (stall_wb),
        .counts   (counts),
        .settled  (settled)
    );

    // register mirror and pair compare
    shadow_regfile shadow0 (
        .clk       (clk),
        .reset     (reset),
        .retire    (retire),
        .pair_diff (pair_diff)
    );

    // enable and error report
    consistency_check check0 (
        .clk       (clk),
        .reset     (reset),
        .counts    (counts),
        .settled   (settled),
        .pair_diff (pair_diff),
        .chk_en    (chk_en),
        .report    (report)
    );

endmodule

`default_nettype wire

/* testbench/sqed_commit_monitor_sva.sv */
`timescale 1ns/10ps
`default_nettype none

// concurrent checks on the commit monitor
// bound into the top level so settled is visible
module sqed_commit_monitor_sva (
    input logic                         clk,
    input logic                         reset,
    input sqed_chk_pkg::commit_counts_t counts,
    input logic                         settled,
    input logic                         chk_en,
    input sqed_chk_pkg::qed_report_t    report
);

    // failed assertion count
    int fail_count = 0;

    // enable is nothing more than count equality
    a_chk_en_equal: assert property (
        @(posedge clk) disable iff (reset)
            chk_en == (counts.orig == counts.dup)
    ) else begin
        $error("chk_en differs from orig == dup");
        fail_count++;
    end

    // counters frozen at zero until the settling steps finish
    a_counts_idle: assert property (
        @(posedge clk) disable iff (reset)
            !settled |-> (counts == '0)
    ) else begin
        $error("counts moved before the monitor settled");
        fail_count++;
    end

    // registered error needs an enabled check one cycle back
    a_error_after_en: assert property (
        @(posedge clk) disable iff (reset)
            report.error |-> $past(chk_en)
    ) else begin
        $error("report.error without chk_en in the previous cycle");
        fail_count++;
    end

endmodule

bind sqed_commit_monitor sqed_commit_monitor_sva sva0 (
    .clk     (clk),
    .reset   (reset),
    .counts  (counts),
    .settled (settled),
    .chk_en  (chk_en),
    .report  (report)
);

`default_nettype wire

/* testbench/tb_sqed_commit_monitor.sv */
`timescale 1ns/10ps
`default_nettype none

`include "sqed_consts.svh"

// testbench for the sqed commit monitor
// replays the stimulus file, one line per clock
module tb_sqed_commit_monitor;

    // longest wait for one falling edge, in ns
    localparam int EDGE_TIMEOUT_NS = 200;
    localparam int RESET_CYCLES    = 16;

    logic                         clk = 1'b0;
    logic                         reset;
    sqed_wb_pkg::wb_retire_t      retire;
    logic                         stall_dx;
    logic                         stall_wb;
    sqed_chk_pkg::commit_counts_t counts;
    logic                         chk_en;
    sqed_chk_pkg::qed_report_t    report;

    // stimulus file and position in it
    int fd;
    int line_no;

    // fields of the line being replayed
    int                           line_test;
    logic                         in_stall_dx;
    logic                         in_stall_wb;
    logic                         in_valid;
    logic [`REG_ADDR_WIDTH-1:0]   in_addr;
    logic [`XPR_LEN-1:0]          in_data;
    logic [`COMMIT_CNT_WIDTH-1:0] exp_orig;
    logic [`COMMIT_CNT_WIDTH-1:0] exp_dup;
    logic                         exp_chk_en;
    logic                         exp_error;
    logic [`REG_IDX_WIDTH-1:0]    exp_pair;

    // per-test and total bookkeeping
    int cur_test;
    int test_lines;
    int test_errors;
    int num_tests;
    int total_checks;
    int total_errors;
    int cycle;
    bit run_ok;
    bit pending;
    bit more_lines;
    bit line_ready;
    bit edge_ok;

    // 40 ns period
    always #20 clk = ~clk;

    sqed_commit_monitor dut0 (
        .clk      (clk),
        .reset    (reset),
        .retire   (retire),
        .stall_dx (stall_dx),
        .stall_wb (stall_wb),
        .counts   (counts),
        .chk_en   (chk_en),
        .report   (report)
    );

    // poll in 1 ns steps for a high to low clock change
    task automatic wait_fall(output bit ok);
        int   waited;
        logic prev;
        waited = 0;
        ok     = 1'b0;
        prev   = clk;
        while (!ok && waited < EDGE_TIMEOUT_NS) begin
            #1;
            waited++;
            if (prev === 1'b1 && clk === 1'b0) begin
                ok = 1'b1;
            end
            prev = clk;
        end
    endtask

    // next data line with comment and blank lines skipped
    task automatic read_line(output bit got);
        string text;
        int    n;
        int    fields;
        got = 1'b0;
        n   = 1;
        while (!got && run_ok && n != 0) begin
            n = $fgets(text, fd);
            line_no++;
            if (n > 0 && text.len() > 1 && text[0] != "#") begin
                fields = $sscanf(text, "%d %h %h %h %h %h %h %h %h %h %h",
                                 line_test, in_stall_dx, in_stall_wb, in_valid,
                                 in_addr, in_data, exp_orig, exp_dup,
                                 exp_chk_en, exp_error, exp_pair);
                if (fields == 11) begin
                    got = 1'b1;
                end else if (fields > 0) begin
                    $display("stimulus line %0d is malformed: %0d fields instead of 11",
                             line_no, fields);
                    run_ok = 1'b0;
                end
            end
        end
    endtask

    task automatic drive_line();
        stall_dx         = in_stall_dx;
        stall_wb         = in_stall_wb;
        retire.valid     = in_valid;
        retire.addr.raw  = in_addr;
        retire.data      = in_data;
    endtask

    task automatic log_mismatch(input string name, input logic [31:0] got,
                                input logic [31:0] want);
        $display("** Error: %s = 0x%0h, expected 0x%0h (test %0d, line %0d)",
                 name, got, want, line_test, line_no);
        test_errors++;
        total_errors++;
    endtask

    // outputs after the rising edge that took the pending line
    task automatic check_outputs();
        test_lines++;
        total_checks += 5;
        assert (counts.orig === exp_orig)
            else log_mismatch("counts.orig", counts.orig, exp_orig);
        assert (counts.dup === exp_dup)
            else log_mismatch("counts.dup", counts.dup, exp_dup);
        assert (chk_en === exp_chk_en)
            else log_mismatch("chk_en", chk_en, exp_chk_en);
        assert (report.error === exp_error)
            else log_mismatch("report.error", report.error, exp_error);
        assert (report.pair === exp_pair)
            else log_mismatch("report.pair", report.pair, exp_pair);
    endtask

    // one result line per finished test
    task automatic close_test();
        if (cur_test != 0) begin
            $display("test %0d: %0d lines, %0d errors, %s", cur_test, test_lines,
                     test_errors, (test_errors == 0) ? "ok" : "failed");
            num_tests++;
        end
        test_lines  = 0;
        test_errors = 0;
    endtask

    initial begin
        reset        = 1'b1;
        retire       = '0;
        stall_dx     = 1'b1;
        stall_wb     = 1'b1;
        line_no      = 0;
        cur_test     = 0;
        test_lines   = 0;
        test_errors  = 0;
        num_tests    = 0;
        total_checks = 0;
        total_errors = 0;
        run_ok       = 1'b1;
        pending      = 1'b0;
        more_lines   = 1'b1;
        // polls land half a ns off the clock transitions
        #0.5;
        fd = $fopen("testbench/sqed_monitor_input.txt", "r");
        if (fd == 0) begin
            $display("cannot open testbench/sqed_monitor_input.txt");
            run_ok = 1'b0;
        end
        for (cycle = 0; cycle < RESET_CYCLES && run_ok; cycle++) begin
            wait_fall(edge_ok);
            if (!edge_ok) begin
                $display("timeout: clock stopped during reset");
                run_ok = 1'b0;
            end
        end
        reset = 1'b0;
        // check the previous line, then apply the next one
        while (run_ok && more_lines) begin
            wait_fall(edge_ok);
            if (!edge_ok) begin
                $display("timeout: no falling clock edge within %0d ns", EDGE_TIMEOUT_NS);
                run_ok = 1'b0;
            end else begin
                if (pending) begin
                    check_outputs();
                end
                pending = 1'b0;
                read_line(line_ready);
                if (line_ready) begin
                    if (line_test != cur_test) begin
                        close_test();
                        cur_test = line_test;
                    end
                    drive_line();
                    pending = 1'b1;
                end else begin
                    more_lines   = 1'b0;
                    retire.valid = 1'b0;
                end
            end
        end
        close_test();
        if (fd != 0) begin
            $fclose(fd);
        end
        // bound assertions on the monitor
        if (dut0.sva0.fail_count != 0) begin
            $display("%0d bound assertion failures in the monitor",
                     dut0.sva0.fail_count);
            total_errors += dut0.sva0.fail_count;
        end
        $display("summary: %0d tests, %0d checks, %0d errors",
                 num_tests, total_checks, total_errors);
        if (run_ok && total_errors == 0 && num_tests > 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/sqed_monitor_input.txt */
# test stall_dx stall_wb valid addr data | expected orig dup chk_en error pair
# test is decimal, every other column is hex
1 1 0 0 00 00000000 00 00 1 0 0
1 1 0 1 01 000000a1 00 00 1 0 0
1 1 0 1 11 000000a1 00 00 1 0 0
1 1 0 1 12 000000b2 00 00 1 0 0
1 1 0 1 02 000000b2 00 00 1 0 0
2 0 1 0 00 00000000 00 00 1 0 0
2 1 1 0 00 00000000 00 00 1 0 0
2 1 0 0 00 00000000 00 00 1 0 0
2 0 0 1 04 000000d4 01 00 0 0 0
2 0 0 1 00 12345678 01 00 0 0 0
2 0 0 1 14 000000d4 01 01 1 0 0
2 0 0 1 1f 000000ff 01 02 0 0 0
2 0 0 1 0f 000000ff 02 02 1 0 0
2 0 0 1 10 00000010 02 03 0 0 0
2 1 1 1 01 000000a1 03 03 1 0 0
3 0 0 1 06 00000066 04 03 0 0 0
3 0 0 1 16 00000066 04 04 1 0 0
3 0 0 1 01 000000a1 05 04 0 0 0
3 0 0 1 02 000000b2 06 04 0 0 0
3 0 0 1 01 000000a1 07 04 0 0 0
3 0 0 1 02 000000b2 08 04 0 0 0
3 0 0 1 01 000000a1 09 04 0 0 0
3 0 0 1 02 000000b2 0a 04 0 0 0
3 0 0 1 01 000000a1 0b 04 0 0 0
3 0 0 1 02 000000b2 0c 04 0 0 0
3 0 0 1 01 000000a1 0d 04 0 0 0
3 0 0 1 02 000000b2 0e 04 0 0 0
3 0 0 1 01 000000a1 0f 04 0 0 0
3 0 0 1 02 000000b2 10 04 0 0 0
3 0 0 1 01 000000a1 11 04 0 0 0
3 0 0 1 02 000000b2 12 04 0 0 0
3 0 0 1 01 000000a1 13 04 0 0 0
3 0 0 1 02 000000b2 14 04 0 0 0
3 0 0 1 01 000000a1 15 04 0 0 0
3 0 0 1 02 000000b2 16 04 0 0 0
3 0 0 1 01 000000a1 17 04 0 0 0
3 0 0 1 02 000000b2 18 04 0 0 0
3 0 0 1 01 000000a1 19 04 0 0 0
3 0 0 1 02 000000b2 1a 04 0 0 0
3 0 0 1 01 000000a1 1b 04 0 0 0
3 0 0 1 02 000000b2 1c 04 0 0 0
3 0 0 1 01 000000a1 1d 04 0 0 0
3 0 0 1 02 000000b2 1e 04 0 0 0
3 0 0 1 01 000000a1 1f 04 0 0 0
3 0 0 1 02 000000b2 00 04 0 0 0
3 0 0 1 01 000000a1 01 04 0 0 0
3 0 0 1 02 000000b2 02 04 0 0 0
3 0 0 1 01 000000a1 03 04 0 0 0
3 0 0 1 02 000000b2 04 04 1 0 0
4 0 0 1 05 00000055 05 04 0 0 0
4 0 0 1 15 00000055 05 05 1 0 0
4 0 0 0 00 00000000 05 05 1 0 0
4 0 0 1 17 00000077 05 06 0 0 0
4 0 0 1 07 00000070 06 06 1 0 0
4 0 0 0 00 00000000 06 06 1 1 7
4 0 0 1 07 00000077 07 06 0 1 7
4 0 0 1 17 00000077 07 07 1 0 0
5 0 0 1 19 00000099 07 08 0 0 0
5 0 0 1 13 00000033 07 09 0 0 0
5 0 0 0 00 00000000 07 09 0 0 0
5 0 0 1 01 000000a1 08 09 0 0 0
5 0 0 1 02 000000b2 09 09 1 0 0
5 0 0 0 00 00000000 09 09 1 1 3
5 0 0 1 03 00000033 0a 09 0 1 3
5 0 0 1 10 00000010 0a 0a 1 0 0
5 0 0 0 00 00000000 0a 0a 1 1 9

/* flist.f */
+incdir+include
verilog/sqed_wb_pkg.sv
verilog/sqed_chk_pkg.sv
verilog/commit_tally.sv
verilog/shadow_regfile.sv
verilog/consistency_check.sv
verilog/sqed_commit_monitor.sv
testbench/sqed_commit_monitor_sva.sv
testbench/tb_sqed_commit_monitor.sv

/* Bender.yml */
package:
  name: sqed_commit_monitor

sources:
  # design
  - include_dirs:
      - include
    files:
      - verilog/sqed_wb_pkg.sv
      - verilog/sqed_chk_pkg.sv
      - verilog/commit_tally.sv
      - verilog/shadow_regfile.sv
      - verilog/consistency_check.sv
      - verilog/sqed_commit_monitor.sv
  # testbench
  - target: test
    include_dirs:
      - include
    files:
      - testbench/sqed_commit_monitor_sva.sv
      - testbench/tb_sqed_commit_monitor.sv
